// File: list.f
+incdir+include
logic/cmd_pkg.sv
logic/uart_byte_rx.sv
logic/rx_byte_fifo.sv
logic/cmd_frame_parser.sv
logic/cmd_reg_bank.sv
logic/uart_cmd_top.sv
sim/uart_cmd_assert.sv
sim/uart_cmd_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = uart_cmd_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/uart_cmd_tb.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module uart_cmd_tb;

	import cmd_pkg::*;

	// test lengths in frames
	localparam int N_REG   = 40;
	localparam int N_START = 16;
	localparam int N_BAD   = 6;
	localparam int N_NOISE = 8;
	// noise round is stray bytes plus a frame, counted as two
	localparam int N_FRAMES = N_REG + N_START + N_BAD + 2 * N_NOISE;
	// six bytes of ten bits per frame
	localparam int TIMEOUT_CYCLES = 2 * N_FRAMES * 60 * `CMD_CLKS_PER_BIT + 20000;

	logic        clk;
	logic        reset_n;
	logic        uart_rx;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic [31:0] eth_addr;
	logic [31:0] eth_len;
	logic [31:0] uart_addr;
	logic [31:0] uart_len;
	logic [31:0] src_ip;
	logic [31:0] des_ip;
	logic [47:0] src_mac;
	logic [47:0] des_mac;
	logic        eth_start;
	logic        eth_rd;
	logic        uart_start;
	logic        uart_rd;

	integer      seed;
	logic [31:0] rnd;
	// expected apb read value per opcode
	logic [31:0] model [256];
	logic [7:0]  known_ops [12] = '{op_eth_addr, op_eth_len, op_eth_st, op_uart_addr,
		op_uart_len, op_uart_st, op_src_ip, op_src_mac_h, op_src_mac_l, op_des_ip,
		op_des_mac_h, op_des_mac_l};
	logic [7:0]  exp_errors;
	logic [7:0]  op;
	logic [31:0] data;
	logic [31:0] rdata;
	logic        err;
	logic        rdy;
	int          idx;
	int          noise_count;
	int          exp_eth_pulses = 0;
	int          exp_uart_pulses = 0;
	int          eth_pulses = 0;
	int          uart_pulses = 0;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	uart_cmd_top dut (
		.i_sys_clk    (clk),
		.i_reset_n    (reset_n),
		.i_uart_rx    (uart_rx),
		.i_psel       (psel),
		.i_penable    (penable),
		.i_pwrite     (pwrite),
		.i_paddr      (paddr),
		.o_prdata     (prdata),
		.o_pready     (pready),
		.o_pslverr    (pslverr),
		.o_eth_addr   (eth_addr),
		.o_eth_len    (eth_len),
		.o_uart_addr  (uart_addr),
		.o_uart_len   (uart_len),
		.o_src_ip     (src_ip),
		.o_des_ip     (des_ip),
		.o_src_mac    (src_mac),
		.o_des_mac    (des_mac),
		.o_eth_start  (eth_start),
		.o_eth_rd     (eth_rd),
		.o_uart_start (uart_start),
		.o_uart_rd    (uart_rd)
	);

	////////////////////////////////////////////////////////////////////////////
	// clock, pulse monitor, timeout
	////////////////////////////////////////////////////////////////////////////

	always #50 clk = ~clk;

	// count start pulses as they leave the bank
	always @(posedge clk) begin
		if (reset_n) begin
			if (eth_start) begin
				eth_pulses++;
			end
			if (uart_start) begin
				uart_pulses++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// model
	////////////////////////////////////////////////////////////////////////////

	// apb view of a register after a good frame
	function automatic logic [31:0] expected_readback(input logic [7:0] code,
		input logic [31:0] value);
		logic [31:0] word;
		word = value;
		if (code == op_eth_st || code == op_uart_st) begin
			// start bit reads zero, direction stays
			word = {30'd0, value[1], 1'b0};
		end else if (code == op_src_mac_l || code == op_des_mac_l) begin
			word = {16'h0000, value[15:0]};
		end
		return word;
	endfunction

	function automatic bit is_known_op(input logic [7:0] code);
		bit found;
		found = 1'b0;
		for (int i = 0; i < 12; i++) begin
			if (known_ops[i] == code) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus and check tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// start bit, data lsb first, stop bit
	task automatic send_byte(input logic [7:0] value);
		uart_rx = 1'b0;
		wait_cycles(`CMD_CLKS_PER_BIT);
		for (int i = 0; i < 8; i++) begin
			uart_rx = value[i];
			wait_cycles(`CMD_CLKS_PER_BIT);
		end
		uart_rx = 1'b1;
		wait_cycles(`CMD_CLKS_PER_BIT);
	endtask

	task automatic send_frame(input logic [7:0] code, input logic [31:0] value,
		input logic [7:0] end_byte);
		send_byte(`CMD_SOF);
		send_byte(code);
		// data msb first
		for (int i = 3; i >= 0; i--) begin
			send_byte(value[8*i +: 8]);
		end
		send_byte(end_byte);
	endtask

	task automatic send_good_frame(input logic [7:0] code, input logic [31:0] value);
		send_frame(code, value, `CMD_EOF);
		model[code] = expected_readback(code, value);
		if (code == op_eth_st && value[0]) begin
			exp_eth_pulses++;
		end
		if (code == op_uart_st && value[0]) begin
			exp_uart_pulses++;
		end
		wait_cycles(200);
	endtask

	// one apb transfer, setup then access, sampled at the closing edge
	task automatic apb_transfer(input logic [7:0] addr, input logic write,
		output logic [31:0] rd, output logic slverr, output logic ready);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		rd     = prdata;
		slverr = pslverr;
		ready  = pready;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// every register, status, config outputs, direction and pulse counts
	task automatic verify_registers(input string label);
		logic [31:0] word;
		logic        slverr;
		logic        ready;
		logic [7:0]  code;
		for (int i = 0; i < 12; i++) begin
			code = known_ops[i];
			apb_transfer({code[5:0], 2'b00}, 1'b0, word, slverr, ready);
			check_value($sformatf("%s read %h", label, code), model[code], word);
			check_value($sformatf("%s pslverr %h", label, code), 32'd0, {31'd0, slverr});
		end
		apb_transfer(8'h00, 1'b0, word, slverr, ready);
		check_value({label, " status"}, {16'h0000, exp_errors, 8'h00}, word);
		check_value({label, " eth addr"}, model[op_eth_addr], eth_addr);
		check_value({label, " eth len"}, model[op_eth_len], eth_len);
		check_value({label, " uart addr"}, model[op_uart_addr], uart_addr);
		check_value({label, " uart len"}, model[op_uart_len], uart_len);
		check_value({label, " src ip"}, model[op_src_ip], src_ip);
		check_value({label, " des ip"}, model[op_des_ip], des_ip);
		check_value({label, " src mac high"}, model[op_src_mac_h], src_mac[47:16]);
		check_value({label, " src mac low"}, model[op_src_mac_l], {16'h0000, src_mac[15:0]});
		check_value({label, " des mac high"}, model[op_des_mac_h], des_mac[47:16]);
		check_value({label, " des mac low"}, model[op_des_mac_l], {16'h0000, des_mac[15:0]});
		check_value({label, " eth dir"}, {31'd0, model[op_eth_st][1]}, {31'd0, eth_rd});
		check_value({label, " uart dir"}, {31'd0, model[op_uart_st][1]}, {31'd0, uart_rd});
		check_value({label, " eth pulses"}, exp_eth_pulses, eth_pulses);
		check_value({label, " uart pulses"}, exp_uart_pulses, uart_pulses);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed       = 32'h61d1_6bb4;
		clk        = 1'b0;
		reset_n    = 1'b0;
		uart_rx    = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 8'h00;
		exp_errors = 8'h00;
		for (int i = 0; i < 256; i++) begin
			model[i] = 32'd0;
		end
		repeat (8) @(negedge clk);
		reset_n = 1'b1;
		wait_cycles(4);

		// everything reads zero out of reset
		verify_registers("reset");

		// random good frames on known opcodes
		for (int n = 0; n < N_REG; n++) begin
			rnd  = $random(seed);
			idx  = rnd % 12;
			op   = known_ops[idx];
			data = $random(seed);
			send_good_frame(op, data);
			apb_transfer({op[5:0], 2'b00}, 1'b0, rdata, err, rdy);
			check_value($sformatf("write op %h", op), model[op], rdata);
		end
		verify_registers("writes");

		// start and direction, engines alternate
		for (int n = 0; n < N_START; n++) begin
			op   = n[0] ? op_uart_st : op_eth_st;
			data = $random(seed);
			send_good_frame(op, data);
			check_value($sformatf("direction op %h", op), {31'd0, data[1]},
				{31'd0, (op == op_eth_st) ? eth_rd : uart_rd});
			// a pulse only for frames with bit 0 set
			check_value($sformatf("eth pulses op %h", op), exp_eth_pulses, eth_pulses);
			check_value($sformatf("uart pulses op %h", op), exp_uart_pulses, uart_pulses);
		end
		verify_registers("start");

		// wrong end byte drops the frame and counts an error
		for (int n = 0; n < N_BAD; n++) begin
			rnd  = $random(seed);
			idx  = rnd % 12;
			op   = known_ops[idx];
			data = $random(seed);
			do begin
				rnd = $random(seed);
			end while (rnd[7:0] == `CMD_EOF);
			send_frame(op, data, rnd[7:0]);
			exp_errors++;
			wait_cycles(200);
		end
		verify_registers("bad end");

		// stray bytes between frames, then an unknown opcode
		for (int n = 0; n < N_NOISE; n++) begin
			rnd         = $random(seed);
			noise_count = 1 + rnd[1:0];
			for (int k = 0; k < noise_count; k++) begin
				do begin
					rnd = $random(seed);
				end while (rnd[7:0] == `CMD_SOF || rnd[7:0] == `CMD_EOF);
				send_byte(rnd[7:0]);
			end
			do begin
				rnd = $random(seed);
			end while (is_known_op(rnd[7:0]));
			op   = rnd[7:0];
			data = $random(seed);
			send_frame(op, data, `CMD_EOF);
			wait_cycles(200);
			verify_registers("noise");
		end

		// write access is refused
		apb_transfer({op_eth_addr[5:0], 2'b00}, 1'b1, rdata, err, rdy);
		check_value("apb write pslverr", 32'd1, {31'd0, err});
		check_value("apb write pready", 32'd1, {31'd0, rdy});
		check_value("apb write prdata", 32'd0, rdata);
		// opcode 05 has no register
		apb_transfer(8'h14, 1'b0, rdata, err, rdy);
		check_value("apb unmapped pslverr", 32'd1, {31'd0, err});
		check_value("apb unmapped pready", 32'd1, {31'd0, rdy});
		check_value("apb unmapped prdata", 32'd0, rdata);
		verify_registers("apb error");

		error_count += dut.u_fifo.u_fifo_assert.fail_count;
		error_count += dut.u_bank.u_bank_assert.fail_count;
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: sim/uart_cmd_assert.sv
`timescale 1ns/1ps

module uart_cmd_assert (
	input logic i_sys_clk,
	input logic i_reset_n,
	input logic i_pop,
	input logic i_not_empty,
	input logic i_commit,
	input logic i_frame_error,
	input logic i_eth_start,
	input logic i_uart_start
);

	// failed assertions so far
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// fifo side
	////////////////////////////////////////////////////////////////////////////

	pop_not_empty: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		i_pop |-> i_not_empty)
		else begin
			$error("fifo pop while empty");
			fail_count++;
		end

	////////////////////////////////////////////////////////////////////////////
	// register bank side
	////////////////////////////////////////////////////////////////////////////

	// start outputs are single cycle pulses
	eth_start_one: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		i_eth_start |=> !i_eth_start)
		else begin
			$error("eth start pulse longer than one cycle");
			fail_count++;
		end

	uart_start_one: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		i_uart_start |=> !i_uart_start)
		else begin
			$error("uart start pulse longer than one cycle");
			fail_count++;
		end

	// a frame either commits or errors
	commit_xor_error: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		!(i_commit && i_frame_error))
		else begin
			$error("commit and frame error in the same cycle");
			fail_count++;
		end

endmodule

// fifo instance, bank inputs tied off
bind rx_byte_fifo uart_cmd_assert u_fifo_assert (
	.i_sys_clk     (i_sys_clk),
	.i_reset_n     (i_reset_n),
	.i_pop         (i_pop),
	.i_not_empty   (o_not_empty),
	.i_commit      (1'b0),
	.i_frame_error (1'b0),
	.i_eth_start   (1'b0),
	.i_uart_start  (1'b0)
);

// bank instance, fifo inputs tied off
bind cmd_reg_bank uart_cmd_assert u_bank_assert (
	.i_sys_clk     (i_sys_clk),
	.i_reset_n     (i_reset_n),
	.i_pop         (1'b0),
	.i_not_empty   (1'b1),
	.i_commit      (i_commit),
	.i_frame_error (i_frame_error),
	.i_eth_start   (o_eth_start),
	.i_uart_start  (o_uart_start)
);

// File: logic/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top (
	input  logic        i_sys_clk,
	input  logic        i_reset_n,
	input  logic        i_uart_rx,
	input  logic        i_psel,
	input  logic        i_penable,
	input  logic        i_pwrite,
	input  logic [7:0]  i_paddr,
	output logic [31:0] o_prdata,
	output logic        o_pready,
	output logic        o_pslverr,
	output logic [31:0] o_eth_addr,
	output logic [31:0] o_eth_len,
	output logic [31:0] o_uart_addr,
	output logic [31:0] o_uart_len,
	output logic [31:0] o_src_ip,
	output logic [31:0] o_des_ip,
	output logic [47:0] o_src_mac,
	output logic [47:0] o_des_mac,
	output logic        o_eth_start,
	output logic        o_eth_rd,
	output logic        o_uart_start,
	output logic        o_uart_rd
);

	import cmd_pkg::*;

	// receiver to fifo
	logic [7:0]  rx_byte;
	logic        rx_byte_valid;
	// fifo to parser
	logic [7:0]  fifo_head;
	logic        fifo_not_empty;
	logic        fifo_pop;
	logic [7:0]  overflow_count;
	// parser to bank
	logic        commit;
	cmd_opcode_e parse_opcode;
	logic [31:0] parse_data;
	logic        frame_error;

	////////////////////////////////////////////////////////////////////////////
	// byte path: receiver, fifo, parser
	////////////////////////////////////////////////////////////////////////////

	uart_byte_rx u_rx (
		.i_sys_clk    (i_sys_clk),
		.i_reset_n    (i_reset_n),
		.i_uart_rx    (i_uart_rx),
		.o_byte       (rx_byte),
		.o_byte_valid (rx_byte_valid)
	);

	rx_byte_fifo u_fifo (
		.i_sys_clk        (i_sys_clk),
		.i_reset_n        (i_reset_n),
		.i_push           (rx_byte_valid),
		.i_push_data      (rx_byte),
		.i_pop            (fifo_pop),
		.o_head           (fifo_head),
		.o_not_empty      (fifo_not_empty),
		.o_overflow_count (overflow_count)
	);

	cmd_frame_parser u_parser (
		.i_sys_clk     (i_sys_clk),
		.i_reset_n     (i_reset_n),
		.i_byte        (fifo_head),
		.i_byte_avail  (fifo_not_empty),
		.o_pop         (fifo_pop),
		.o_commit      (commit),
		.o_opcode      (parse_opcode),
		.o_data        (parse_data),
		.o_frame_error (frame_error)
	);

	// config registers and apb view
	cmd_reg_bank u_bank (
		.i_sys_clk        (i_sys_clk),
		.i_reset_n        (i_reset_n),
		.i_commit         (commit),
		.i_opcode         (parse_opcode),
		.i_data           (parse_data),
		.i_frame_error    (frame_error),
		.i_overflow_count (overflow_count),
		.i_psel           (i_psel),
		.i_penable        (i_penable),
		.i_pwrite         (i_pwrite),
		.i_paddr          (i_paddr),
		.o_prdata         (o_prdata),
		.o_pready         (o_pready),
		.o_pslverr        (o_pslverr),
		.o_eth_addr       (o_eth_addr),
		.o_eth_len        (o_eth_len),
		.o_uart_addr      (o_uart_addr),
		.o_uart_len       (o_uart_len),
		.o_src_ip         (o_src_ip),
		.o_des_ip         (o_des_ip),
		.o_src_mac        (o_src_mac),
		.o_des_mac        (o_des_mac),
		.o_eth_start      (o_eth_start),
		.o_eth_rd         (o_eth_rd),
		.o_uart_start     (o_uart_start),
		.o_uart_rd        (o_uart_rd)
	);

endmodule

// File: logic/cmd_reg_bank.sv
`timescale 1ns/1ps

module cmd_reg_bank (
	input  logic                i_sys_clk,
	input  logic                i_reset_n,
	input  logic                i_commit,
	input  cmd_pkg::cmd_opcode_e i_opcode,
	input  logic [31:0]         i_data,
	input  logic                i_frame_error,
	input  logic [7:0]          i_overflow_count,
	input  logic                i_psel,
	input  logic                i_penable,
	input  logic                i_pwrite,
	input  logic [7:0]          i_paddr,
	output logic [31:0]         o_prdata,
	output logic                o_pready,
	output logic                o_pslverr,
	output logic [31:0]         o_eth_addr,
	output logic [31:0]         o_eth_len,
	output logic [31:0]         o_uart_addr,
	output logic [31:0]         o_uart_len,
	output logic [31:0]         o_src_ip,
	output logic [31:0]         o_des_ip,
	output logic [47:0]         o_src_mac,
	output logic [47:0]         o_des_mac,
	output logic                o_eth_start,
	output logic                o_eth_rd,
	output logic                o_uart_start,
	output logic                o_uart_rd
);

	import cmd_pkg::*;

	logic [7:0]  err_count;
	cmd_opcode_e apb_sel;
	logic        apb_access;
	logic        rd_hit;
	logic [31:0] rd_word;

	////////////////////////////////////////////////////////////////////////////
	// register writes from committed frames
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			o_eth_addr   <= '0;
			o_eth_len    <= '0;
			o_uart_addr  <= '0;
			o_uart_len   <= '0;
			o_src_ip     <= '0;
			o_des_ip     <= '0;
			o_src_mac    <= '0;
			o_des_mac    <= '0;
			o_eth_start  <= 1'b0;
			o_eth_rd     <= 1'b0;
			o_uart_start <= 1'b0;
			o_uart_rd    <= 1'b0;
		end else begin
			// start is a single cycle pulse
			o_eth_start  <= 1'b0;
			o_uart_start <= 1'b0;
			if (i_commit) begin
				case (i_opcode)
					op_eth_addr:  o_eth_addr <= i_data;
					op_eth_len:   o_eth_len  <= i_data;
					op_eth_st: begin
						// bit 0 starts, bit 1 picks read
						o_eth_start <= i_data[0];
						o_eth_rd    <= i_data[1];
					end
					op_uart_addr: o_uart_addr <= i_data;
					op_uart_len:  o_uart_len  <= i_data;
					op_uart_st: begin
						o_uart_start <= i_data[0];
						o_uart_rd    <= i_data[1];
					end
					op_src_ip:    o_src_ip <= i_data;
					// mac high word is bits 47:16
					op_src_mac_h: o_src_mac[47:16] <= i_data;
					// low half only keeps 16 bits
					op_src_mac_l: o_src_mac[15:0] <= i_data[15:0];
					op_des_ip:    o_des_ip <= i_data;
					op_des_mac_h: o_des_mac[47:16] <= i_data;
					op_des_mac_l: o_des_mac[15:0] <= i_data[15:0];
					// unknown opcode, nothing changes
					default: ;
				endcase
			end
		end
	end

	// frame errors, saturating
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			err_count <= '0;
		end else if (i_frame_error && err_count != 8'hff) begin
			err_count <= err_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// apb read side, no wait states
	////////////////////////////////////////////////////////////////////////////

	// word address doubles as the opcode
	assign apb_sel    = cmd_opcode_e'({2'b00, i_paddr[7:2]});
	assign apb_access = i_psel && i_penable;

	always_comb begin
		rd_word = '0;
		rd_hit  = 1'b1;
		if (i_paddr[1:0] != 2'b00) begin
			// unaligned
			rd_hit = 1'b0;
		end else if (i_paddr[7:2] == 6'd0) begin
			rd_word = {16'h0000, err_count, i_overflow_count};
		end else begin
			case (apb_sel)
				op_eth_addr:  rd_word = o_eth_addr;
				op_eth_len:   rd_word = o_eth_len;
				// start reads back zero, direction in bit 1
				op_eth_st:    rd_word = {30'd0, o_eth_rd, 1'b0};
				op_uart_addr: rd_word = o_uart_addr;
				op_uart_len:  rd_word = o_uart_len;
				op_uart_st:   rd_word = {30'd0, o_uart_rd, 1'b0};
				op_src_ip:    rd_word = o_src_ip;
				op_src_mac_h: rd_word = o_src_mac[47:16];
				op_src_mac_l: rd_word = {16'h0000, o_src_mac[15:0]};
				op_des_ip:    rd_word = o_des_ip;
				op_des_mac_h: rd_word = o_des_mac[47:16];
				op_des_mac_l: rd_word = {16'h0000, o_des_mac[15:0]};
				default:      rd_hit  = 1'b0;
			endcase
		end
	end

	assign o_pready  = 1'b1;
	// writes are not supported, error answers read zero
	assign o_pslverr = apb_access && (i_pwrite || !rd_hit);
	assign o_prdata  = (apb_access && !i_pwrite && rd_hit) ? rd_word : 32'd0;

endmodule

// File: logic/cmd_frame_parser.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module cmd_frame_parser (
	input  logic                i_sys_clk,
	input  logic                i_reset_n,
	input  logic [7:0]          i_byte,
	input  logic                i_byte_avail,
	output logic                o_pop,
	output logic                o_commit,
	output cmd_pkg::cmd_opcode_e o_opcode,
	output logic [31:0]         o_data,
	output logic                o_frame_error
);

	import cmd_pkg::*;

	parse_state_e state;
	// data bytes taken so far
	logic [1:0]   byte_cnt;

	// always ready, one byte per cycle
	assign o_pop = i_byte_avail;

	////////////////////////////////////////////////////////////////////////////
	// frame fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state         <= ps_idle;
			byte_cnt      <= '0;
			o_commit      <= 1'b0;
			o_frame_error <= 1'b0;
		end else begin
			// strobes last one cycle
			o_commit      <= 1'b0;
			o_frame_error <= 1'b0;
			if (i_byte_avail) begin
				case (state)
					ps_idle: begin
						// anything but the opening brace is noise
						if (i_byte == `CMD_SOF) begin
							state <= ps_opcode;
						end
					end
					ps_opcode: begin
						byte_cnt <= '0;
						state    <= ps_data;
					end
					ps_data: begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == 2'd3) begin
							state <= ps_end;
						end
					end
					ps_end: begin
						// bad end byte drops the frame
						if (i_byte == `CMD_EOF) begin
							o_commit <= 1'b1;
						end else begin
							o_frame_error <= 1'b1;
						end
						state <= ps_idle;
					end
					default: state <= ps_idle;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// opcode and data capture
	////////////////////////////////////////////////////////////////////////////

	// held stable through the commit cycle, next frame needs two pops first
	always_ff @(posedge i_sys_clk) begin
		if (i_byte_avail && state == ps_opcode) begin
			o_opcode <= cmd_opcode_e'(i_byte);
		end
		// msb first, shift up
		if (i_byte_avail && state == ps_data) begin
			o_data <= {o_data[23:0], i_byte};
		end
	end

endmodule

// File: logic/rx_byte_fifo.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module rx_byte_fifo (
	input  logic       i_sys_clk,
	input  logic       i_reset_n,
	input  logic       i_push,
	input  logic [7:0] i_push_data,
	input  logic       i_pop,
	output logic [7:0] o_head,
	output logic       o_not_empty,
	output logic [7:0] o_overflow_count
);

	localparam int AW = $clog2(`CMD_FIFO_DEPTH);

	logic [7:0]  mem [`CMD_FIFO_DEPTH];
	// extra msb tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        empty;
	logic        push_ok;
	logic        pop_ok;

	assign empty   = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push_ok = i_push && !full;
	assign pop_ok  = i_pop && !empty;

	// storage
	always_ff @(posedge i_sys_clk) begin
		if (push_ok) begin
			mem[wr_ptr[AW-1:0]] <= i_push_data;
		end
	end

	// pointers and overflow count
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			wr_ptr           <= '0;
			rd_ptr           <= '0;
			o_overflow_count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// dropped byte, count saturates at 255
			if (i_push && full && o_overflow_count != 8'hff) begin
				o_overflow_count <= o_overflow_count + 1'b1;
			end
		end
	end

	// head byte is read combinationally, pop takes it the same cycle
	assign o_head      = mem[rd_ptr[AW-1:0]];
	assign o_not_empty = !empty;

endmodule

// File: logic/uart_byte_rx.sv
`timescale 1ns/1ps
`include "cmd_params.svh"

module uart_byte_rx (
	input  logic       i_sys_clk,
	input  logic       i_reset_n,
	input  logic       i_uart_rx,
	output logic [7:0] o_byte,
	output logic       o_byte_valid
);

	import cmd_pkg::*;

	localparam int CNT_W = $clog2(`CMD_CLKS_PER_BIT);
	// last count of a full bit, and of half a bit
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`CMD_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`CMD_CLKS_PER_BIT / 2 - 1);

	rx_state_e        state;
	logic [1:0]       rx_sync;
	logic             rx_s;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;

	////////////////////////////////////////////////////////////////////////////
	// line synchronizer
	////////////////////////////////////////////////////////////////////////////

	// two flops against metastability, line idles high
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], i_uart_rx};
		end
	end

	assign rx_s = rx_sync[1];

	////////////////////////////////////////////////////////////////////////////
	// bit timing and state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state        <= rx_idle;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			o_byte_valid <= 1'b0;
		end else begin
			o_byte_valid <= 1'b0;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// falling edge opens a start bit
					if (!rx_s) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						// glitch shorter than half a bit goes back to idle
						state   <= rx_s ? rx_idle : rx_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt      <= '0;
						// low stop bit means a framing fault, byte is dropped
						o_byte_valid <= rx_s;
						state        <= rx_idle;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// data shifts in lsb first at each bit middle
	always_ff @(posedge i_sys_clk) begin
		if (state == rx_data && clk_cnt == BIT_LAST) begin
			shift_reg <= {rx_s, shift_reg[7:1]};
		end
	end

	assign o_byte = shift_reg;

endmodule

// File: logic/cmd_pkg.sv
package cmd_pkg;

	// serial receiver phases
	typedef enum logic [1:0] {
		rx_idle  = 2'd0,
		rx_start = 2'd1,
		rx_data  = 2'd2,
		rx_stop  = 2'd3
	} rx_state_e;

	// frame parser phases, one per part of the frame
	typedef enum logic [1:0] {
		ps_idle   = 2'd0,
		ps_opcode = 2'd1,
		ps_data   = 2'd2,
		ps_end    = 2'd3
	} parse_state_e;

	// register opcodes carried in the second frame byte
	// apb byte address of a register = opcode * 4
	// apb address 0 is status: [15:8] frame errors, [7:0] fifo overflows
	typedef enum logic [7:0] {
		op_eth_addr  = 8'h01,
		op_eth_len   = 8'h02,
		op_eth_st    = 8'h03,
		op_uart_addr = 8'h11,
		op_uart_len  = 8'h12,
		op_uart_st   = 8'h13,
		op_src_ip    = 8'h21,
		op_src_mac_h = 8'h22,
		op_src_mac_l = 8'h23,
		op_des_ip    = 8'h24,
		op_des_mac_h = 8'h25,
		op_des_mac_l = 8'h26
	} cmd_opcode_e;

endpackage

// File: include/cmd_params.svh
`ifndef CMD_PARAMS_SVH
`define CMD_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// serial timing
////////////////////////////////////////////////////////////////////////////

// system clocks per serial bit
// kept small so a frame stays under a thousand cycles
`define CMD_CLKS_PER_BIT 16

////////////////////////////////////////////////////////////////////////////
// byte buffer
////////////////////////////////////////////////////////////////////////////

// byte slots in the rx fifo, power of two
`define CMD_FIFO_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// frame markers
////////////////////////////////////////////////////////////////////////////

// opening brace '{'
`define CMD_SOF 8'h7b
// closing brace '}'
`define CMD_EOF 8'h7d

`endif
